//--- hw/engine_pkg.sv
`default_nettype none

package engine_pkg;

    // --------------------
    // Packet format
    // --------------------

    // Fixed payload width of one engine packet
    localparam int PACKET_WIDTH = 64;

    typedef logic [PACKET_WIDTH-1:0] packet_t;

    // --------------------
    // FIFO occupancy
    // --------------------

    // Counter must reach the full depth, so one spare bit over 5
    localparam int FIFO_LEVEL_WIDTH = 6;
    localparam int FIFO_MAX_DEPTH   = 32;

    typedef logic [FIFO_LEVEL_WIDTH-1:0] fifo_level_t;

    // --------------------
    // Outbound bus master
    // --------------------

    typedef enum logic [0:0] {
        EGRESS_IDLE,
        EGRESS_BUS
    } egress_state_t;

endpackage

`default_nettype wire

//--- hw/packet_fifo.sv
`default_nettype none

module packet_fifo #(
    parameter int DEPTH       = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic                ap_clk,
    input  logic                rst,
    input  logic                wr_en,
    input  engine_pkg::packet_t din,
    input  logic                rd_en,
    output engine_pkg::packet_t dout,
    output logic                valid,
    output logic                empty,
    output logic                full,
    output logic                prog_full
);

    localparam int ADDR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef logic [ADDR_WIDTH-1:0] addr_t;

    engine_pkg::packet_t     mem [DEPTH];
    addr_t                   wr_ptr;
    addr_t                   rd_ptr;
    engine_pkg::fifo_level_t count;
    logic                    do_write;
    logic                    do_read;

    // Pointer step, wraps for depths that are not a power of two
    function automatic addr_t next_ptr(input addr_t ptr);
        if (ptr == addr_t'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + addr_t'(1);
    endfunction

    // Requests against a full or an empty buffer are ignored
    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    // --------------------
    // Status flags
    // --------------------
    assign empty     = (count == '0);
    assign full      = (count == engine_pkg::fifo_level_t'(DEPTH));
    assign prog_full = (count >= engine_pkg::fifo_level_t'(PROG_THRESH));

    // --------------------
    // Storage
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    // Registered read port
    always_ff @(posedge ap_clk) begin
        if (do_read) begin
            dout <= mem[rd_ptr];
        end
    end

    // --------------------
    // Pointers and level
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            valid <= do_read;
            if (do_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous push and pop leave the level unchanged
            case ({do_write, do_read})
                2'b10: begin
                    count <= count + engine_pkg::fifo_level_t'(1);
                end
                2'b01: begin
                    count <= count - engine_pkg::fifo_level_t'(1);
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/engine_ingress.sv
`default_nettype none

module engine_ingress #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic                ap_clk,
    input  logic                rst,

    // Inbound Wishbone slave
    input  logic                in_cyc,
    input  logic                in_stb,
    input  engine_pkg::packet_t in_dat,
    output logic                in_ack,

    // Toward the pipeline
    input  logic                egress_prog_full,
    output logic                pop_valid,
    output engine_pkg::packet_t pop_dat,

    output logic                ingress_idle
);

    logic ack_q;
    logic fifo_empty;
    logic fifo_full;
    logic rd_en;

    // --------------------
    // Bus acknowledge
    // --------------------

    // One-cycle ack, never on two cycles back to back
    assign in_ack = in_cyc && in_stb && !fifo_full && !ack_q;

    always_ff @(posedge ap_clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= in_ack;
        end
    end

    // --------------------
    // Pop toward pipeline
    // --------------------

    // Egress level gates the flow so the pipeline never stalls
    assign rd_en = !fifo_empty && !egress_prog_full;

    // A packet on the link or being acked still counts as busy
    assign ingress_idle = fifo_empty && !pop_valid && !in_ack;

    packet_fifo #(
        .DEPTH      (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) i_packet_fifo (
        .ap_clk   (ap_clk),
        .rst      (rst),
        .wr_en    (in_ack),
        .din      (in_dat),
        .rd_en    (rd_en),
        .dout     (pop_dat),
        .valid    (pop_valid),
        .empty    (fifo_empty),
        .full     (fifo_full),
        .prog_full()
    );

endmodule

`default_nettype wire

//--- hw/engine_egress.sv
`default_nettype none

module engine_egress #(
    parameter int FIFO_DEPTH      = 16,
    parameter int PROG_THRESH     = 8,
    parameter int PIPELINE_STAGES = 2
) (
    input  logic                ap_clk,
    input  logic                rst,

    // From the ingress FIFO
    input  logic                pop_valid,
    input  engine_pkg::packet_t pop_dat,
    output logic                egress_prog_full,

    // Outbound Wishbone master
    output logic                out_cyc,
    output logic                out_stb,
    output engine_pkg::packet_t out_dat,
    input  logic                out_ack,

    output logic                egress_idle
);

    logic [PIPELINE_STAGES-1:0] stage_valid;
    engine_pkg::packet_t        stage_dat [PIPELINE_STAGES];

    engine_pkg::egress_state_t  state;
    engine_pkg::packet_t        fifo_dout;
    logic                       fifo_valid;
    logic                       fifo_empty;
    logic                       rd_en;

    // --------------------
    // Hyper pipeline
    // --------------------

    // Valid bits need a clean start
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            stage_valid <= '0;
        end else begin
            stage_valid[0] <= pop_valid;
            for (int i = 1; i < PIPELINE_STAGES; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        stage_dat[0] <= pop_dat;
        for (int i = 1; i < PIPELINE_STAGES; i++) begin
            stage_dat[i] <= stage_dat[i-1];
        end
    end

    // --------------------
    // Egress FIFO
    // --------------------
    packet_fifo #(
        .DEPTH      (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) i_packet_fifo (
        .ap_clk   (ap_clk),
        .rst      (rst),
        .wr_en    (stage_valid[PIPELINE_STAGES-1]),
        .din      (stage_dat[PIPELINE_STAGES-1]),
        .rd_en    (rd_en),
        .dout     (fifo_dout),
        .valid    (fifo_valid),
        .empty    (fifo_empty),
        .full     (),
        .prog_full(egress_prog_full)
    );

    // --------------------
    // Bus master FSM
    // --------------------

    // Read when idle, or prefetch on the acked cycle of the current transfer
    assign rd_en = !fifo_empty && !fifo_valid &&
                   ((state == engine_pkg::EGRESS_IDLE) ||
                    ((state == engine_pkg::EGRESS_BUS) && out_ack));

    always_ff @(posedge ap_clk) begin
        if (rst) begin
            state <= engine_pkg::EGRESS_IDLE;
        end else begin
            case (state)
                engine_pkg::EGRESS_IDLE: begin
                    if (fifo_valid) begin
                        state <= engine_pkg::EGRESS_BUS;
                    end
                end
                engine_pkg::EGRESS_BUS: begin
                    // Strobe drops for a cycle before the next packet
                    if (out_ack) begin
                        state <= engine_pkg::EGRESS_IDLE;
                    end
                end
                default: begin
                    state <= engine_pkg::EGRESS_IDLE;
                end
            endcase
        end
    end

    // Read data only arrives in EGRESS_IDLE, so out_dat holds through the bus cycle
    always_ff @(posedge ap_clk) begin
        if (fifo_valid) begin
            out_dat <= fifo_dout;
        end
    end

    assign out_stb = (state == engine_pkg::EGRESS_BUS);
    assign out_cyc = (state == engine_pkg::EGRESS_BUS);

    assign egress_idle = !(|stage_valid) && fifo_empty && !fifo_valid &&
                         (state == engine_pkg::EGRESS_IDLE);

endmodule

`default_nettype wire

//--- hw/engine_pipeline_top.sv
`default_nettype none

module engine_pipeline_top #(
    parameter int FIFO_DEPTH      = 16,
    parameter int PROG_THRESH     = 8,
    parameter int PIPELINE_STAGES = 2
) (
    input  logic                ap_clk,
    input  logic                areset_template_engine,

    // Inbound Wishbone slave port
    input  logic                in_cyc,
    input  logic                in_stb,
    input  engine_pkg::packet_t in_dat,
    output logic                in_ack,

    // Outbound Wishbone master port
    output logic                out_cyc,
    output logic                out_stb,
    output engine_pkg::packet_t out_dat,
    input  logic                out_ack,

    output logic                done,
    output logic                setup
);

    logic                rst_q;
    logic                pop_valid;
    engine_pkg::packet_t pop_dat;
    logic                egress_prog_full;
    logic                ingress_idle;
    logic                egress_idle;

    // --------------------
    // Parameter check
    // --------------------

    // Headroom for packets in flight once the egress FIFO reports prog_full
    if ((PIPELINE_STAGES < 1) || (PROG_THRESH < 1) ||
        (PROG_THRESH + PIPELINE_STAGES + 2 > FIFO_DEPTH) ||
        (FIFO_DEPTH > engine_pkg::FIFO_MAX_DEPTH)) begin : g_param_check
        $error("engine_pipeline_top: unsupported FIFO_DEPTH/PROG_THRESH/PIPELINE_STAGES");
    end

    // --------------------
    // Reset and status
    // --------------------
    always_ff @(posedge ap_clk) begin
        rst_q <= areset_template_engine;
    end

    assign setup = areset_template_engine || rst_q;

    // Idle as seen one cycle earlier
    always_ff @(posedge ap_clk) begin
        if (rst_q) begin
            done <= 1'b0;
        end else begin
            done <= ingress_idle && egress_idle;
        end
    end

    // --------------------
    // Packet path
    // --------------------
    engine_ingress #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) i_engine_ingress (
        .ap_clk          (ap_clk),
        .rst             (rst_q),
        .in_cyc          (in_cyc),
        .in_stb          (in_stb),
        .in_dat          (in_dat),
        .in_ack          (in_ack),
        .egress_prog_full(egress_prog_full),
        .pop_valid       (pop_valid),
        .pop_dat         (pop_dat),
        .ingress_idle    (ingress_idle)
    );

    engine_egress #(
        .FIFO_DEPTH     (FIFO_DEPTH),
        .PROG_THRESH    (PROG_THRESH),
        .PIPELINE_STAGES(PIPELINE_STAGES)
    ) i_engine_egress (
        .ap_clk          (ap_clk),
        .rst             (rst_q),
        .pop_valid       (pop_valid),
        .pop_dat         (pop_dat),
        .egress_prog_full(egress_prog_full),
        .out_cyc         (out_cyc),
        .out_stb         (out_stb),
        .out_dat         (out_dat),
        .out_ack         (out_ack),
        .egress_idle     (egress_idle)
    );

endmodule

`default_nettype wire

//--- test/engine_pipeline_properties.sv
`default_nettype none

module engine_pipeline_properties (
    input logic                ap_clk,
    input logic                rst,
    input logic                cyc,
    input logic                stb,
    input logic                ack,
    input engine_pkg::packet_t dat
);

    timeunit 1ns;
    timeprecision 100ps;

    // Request and payload stay put until the slave acks
    request_held: assert property (@(posedge ap_clk) disable iff (rst)
        (cyc && stb && !ack) |=> (cyc && stb && $stable(dat)))
        else $error("bus request changed before its ack");

    ack_single: assert property (@(posedge ap_clk) disable iff (rst) ack |=> !ack)
        else $error("ack held for more than one cycle");

    ack_needs_request: assert property (@(posedge ap_clk) disable iff (rst)
        ack |-> (cyc && stb))
        else $error("ack without cyc and stb");

endmodule

bind engine_ingress engine_pipeline_properties i_ingress_properties (
    .ap_clk(ap_clk), .rst(rst), .cyc(in_cyc), .stb(in_stb), .ack(in_ack),
    .dat(in_dat)
);

bind engine_egress engine_pipeline_properties i_egress_properties (
    .ap_clk(ap_clk), .rst(rst), .cyc(out_cyc), .stb(out_stb), .ack(out_ack),
    .dat(out_dat)
);

`default_nettype wire

//--- test/engine_pipeline_tb.sv
`default_nettype none

module engine_pipeline_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FIFO_DEPTH      = 16;
    localparam int PROG_THRESH     = 8;
    localparam int PIPELINE_STAGES = 2;
    localparam int CLK_PERIOD      = 4;
    localparam int PACKET_COUNT    = 200;
    localparam int ACCEPT_LIMIT    = 2 * FIFO_DEPTH + PIPELINE_STAGES + 2;

    integer seed = 32'h5f54_f4df;

    logic                ap_clk;
    logic                areset_template_engine;
    logic                in_cyc;
    logic                in_stb;
    engine_pkg::packet_t in_dat;
    logic                in_ack;
    logic                out_cyc;
    logic                out_stb;
    engine_pkg::packet_t out_dat;
    logic                out_ack;
    logic                done;
    logic                setup;

    // Reference model of packets in acked order
    engine_pkg::packet_t model_q[$];

    engine_pkg::packet_t offer_dat    = '0;
    bit                  offering     = 1'b0;
    bit                  hold_out_ack = 1'b0;
    bit                  burst_mode   = 1'b0;
    int                  send_target  = 0;
    int                  sent_count   = 0;
    int                  recv_count   = 0;
    int                  gap_left     = 0;
    int                  ack_delay    = -1;

    engine_pipeline_top #(
        .FIFO_DEPTH     (FIFO_DEPTH),
        .PROG_THRESH    (PROG_THRESH),
        .PIPELINE_STAGES(PIPELINE_STAGES)
    ) i_engine_pipeline_top (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .in_cyc                (in_cyc),
        .in_stb                (in_stb),
        .in_dat                (in_dat),
        .in_ack                (in_ack),
        .out_cyc               (out_cyc),
        .out_stb               (out_stb),
        .out_dat               (out_dat),
        .out_ack               (out_ack),
        .done                  (done),
        .setup                 (setup)
    );

    initial begin
        ap_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
        end
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "stopping after the first error");
    endtask

    // --------------------
    // One bus cycle
    // --------------------

    // Drive on the falling edge and sample 1 ns later while outputs are settled
    task automatic run_cycle();
        engine_pkg::packet_t expected;
        @(negedge ap_clk);
        if (!offering && (sent_count < send_target)) begin
            if (gap_left > 0) begin
                gap_left--;
            end else begin
                offering  = 1'b1;
                offer_dat = {$random(seed), $random(seed)};
            end
        end
        in_cyc = offering;
        in_stb = offering;
        in_dat = offer_dat;
        // Outbound slave waits a random number of cycles before each ack
        if (out_stb && !hold_out_ack) begin
            if (ack_delay < 0) begin
                ack_delay = $unsigned($random(seed)) % 6;
            end
            if (ack_delay == 0) begin
                out_ack = 1'b1;
            end else begin
                out_ack = 1'b0;
                ack_delay--;
            end
        end else begin
            out_ack = 1'b0;
        end
        #1;
        if (out_stb) begin
            assert (!done) else stop_on_error($sformatf(
                "error: done = 0x%0h while out_stb = 0x%0h", done, out_stb));
            assert (out_cyc) else stop_on_error($sformatf(
                "error: out_cyc = 0x%0h while out_stb = 0x%0h", out_cyc, out_stb));
        end
        if (model_q.size() > 0) begin
            assert (!done) else stop_on_error($sformatf(
                "error: done = 0x%0h with %0d packets in flight", done, model_q.size()));
        end
        if (out_stb && out_ack) begin
            assert (model_q.size() > 0) else stop_on_error(
                "an outbound packet arrived with no packet pending");
            expected = model_q.pop_front();
            assert (out_dat == expected) else stop_on_error($sformatf(
                "error: out_dat = 0x%h, expected 0x%h", out_dat, expected));
            recv_count++;
            ack_delay = -1;
        end
        if (in_ack) begin
            assert (offering) else stop_on_error("in_ack came with no packet offered");
            model_q.push_back(offer_dat);
            sent_count++;
            offering = 1'b0;
            if (burst_mode) begin
                gap_left = 0;
            end else begin
                gap_left = $unsigned($random(seed)) % 4;
            end
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        int waited;
        int quiet;
        int prev_sent;
        int hold_start;

        areset_template_engine = 1'b1;
        in_cyc  = 1'b0;
        in_stb  = 1'b0;
        in_dat  = '0;
        out_ack = 1'b0;

        repeat (2) begin
            @(negedge ap_clk);
            assert (setup) else stop_on_error($sformatf("error: setup = 0x%0h in reset", setup));
        end
        areset_template_engine = 1'b0;
        #1;
        // Registered reset still high for one more cycle
        assert (setup) else stop_on_error($sformatf("error: setup = 0x%0h after reset", setup));
        @(negedge ap_clk);
        #1;
        assert (!setup) else stop_on_error($sformatf("error: setup = 0x%0h", setup));
        assert (!in_ack) else stop_on_error($sformatf("error: in_ack = 0x%0h", in_ack));
        assert (!out_cyc) else stop_on_error($sformatf("error: out_cyc = 0x%0h", out_cyc));
        assert (!out_stb) else stop_on_error($sformatf("error: out_stb = 0x%0h", out_stb));
        assert (!done) else stop_on_error($sformatf("error: done = 0x%0h", done));

        // Random traffic with gaps and ack delays
        send_target = PACKET_COUNT;
        waited = 0;
        while (recv_count < PACKET_COUNT) begin
            assert (waited < PACKET_COUNT * 20) else stop_on_error(
                "timed out waiting for the random packets to leave");
            run_cycle();
            waited++;
        end

        // Idle path must report done and keep it
        waited = 0;
        while (!done) begin
            assert (waited < 50) else stop_on_error("done never rose on an idle path");
            run_cycle();
            waited++;
        end
        repeat (20) begin
            run_cycle();
            assert (done) else stop_on_error($sformatf("error: done = 0x%0h while idle", done));
        end

        // Stalled outbound port makes the ingress stop acking
        hold_out_ack = 1'b1;
        burst_mode   = 1'b1;
        hold_start   = sent_count;
        send_target  = sent_count + 1000;
        quiet  = 0;
        waited = 0;
        while (quiet < 40) begin
            assert (waited < 500) else stop_on_error("in_ack never stopped under back-pressure");
            prev_sent = sent_count;
            run_cycle();
            if (sent_count == prev_sent) begin
                quiet++;
            end else begin
                quiet = 0;
            end
            waited++;
        end
        assert (sent_count - hold_start <= ACCEPT_LIMIT) else stop_on_error(
            "too many packets accepted while the outbound port was stalled");

        // The pending offer still completes after the release
        hold_out_ack = 1'b0;
        send_target  = sent_count + (offering ? 1 : 0);
        waited = 0;
        while (offering || (model_q.size() > 0)) begin
            assert (waited < 2000) else stop_on_error("timed out draining after back-pressure");
            run_cycle();
            waited++;
        end
        assert (recv_count == sent_count) else stop_on_error("packet count mismatch at the end");

        waited = 0;
        while (!done) begin
            assert (waited < 50) else stop_on_error("done never rose after the final drain");
            run_cycle();
            waited++;
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hw/engine_pkg.sv
hw/packet_fifo.sv
hw/engine_ingress.sv
hw/engine_egress.sv
hw/engine_pipeline_top.sv
test/engine_pipeline_properties.sv
test/engine_pipeline_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the engine packet path testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/100ps \
    --top-module engine_pipeline_tb -f list.f -o engine_pipeline_sim \
    && ./obj_dir/engine_pipeline_sim | tee /dev/stderr | grep "test passed" > /dev/null \
    && echo "simulation run: PASS" \
    || { echo "simulation run: FAIL"; exit 1; }

exit 0
